/* compile.f */
verilog/adaptive_cache_pkg.sv
verilog/way_store.sv
verilog/plru_tree.sv
verilog/cache_ctrl_fsm.sv
verilog/assoc_tuner.sv
verilog/adaptive_cache.sv
tests/line_memory.sv
tests/tb_adaptive_cache.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_adaptive_cache
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= ** PASS **

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qxF '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)

/* tests/tb_adaptive_cache.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_adaptive_cache;

    localparam int WAYS       = 4;
    localparam int TUNE_LIMIT = 4;
    localparam int SH_ENTRIES = adaptive_cache_pkg::SETS * WAYS;
    localparam int N_RANDOM   = 150;   // each one followed by a repeat read
    localparam int N_BURST    = 40;
    localparam int N_STREAM   = 60;
    localparam int N_FINAL    = 10;
    localparam int N_REQ      = 2 * N_RANDOM + N_BURST + N_STREAM + 2 * N_FINAL;
    localparam int TIMEOUT    = 3000 + 40 * N_REQ;

    logic                            clk;
    logic                            rst;
    adaptive_cache_pkg::addr_t       addr;
    adaptive_cache_pkg::byte_mask_t  rmask;
    adaptive_cache_pkg::byte_mask_t  wmask;
    adaptive_cache_pkg::word_t       wdata;
    adaptive_cache_pkg::word_t       rdata;
    logic                            resp;
    adaptive_cache_pkg::addr_t       mem_addr;
    logic                            mem_read;
    logic                            mem_write;
    adaptive_cache_pkg::line_t       mem_wdata;
    adaptive_cache_pkg::line_t       mem_rdata;
    logic                            mem_resp;
    adaptive_cache_pkg::assoc_mode_t assoc_mode;

    // byte-addressed memory model and tuner model
    logic [7:0] model_mem [adaptive_cache_pkg::addr_t];
    bit touched [adaptive_cache_pkg::line_addr_t];
    logic sh_valid [SH_ENTRIES];
    adaptive_cache_pkg::line_addr_t sh_line [SH_ENTRIES];
    int sh_ptr;
    int tune_cnt;
    int exp_mode;

    int data_errors;
    int timing_errors;
    int mode_errors;
    int wb_errors;
    int other_errors;
    int wb_seen;
    int cycle_count;

    adaptive_cache #(
        .WAYS      (WAYS),
        .TUNE_LIMIT(TUNE_LIMIT)
    ) adaptive_cache_inst (
        .clk       (clk),
        .rst       (rst),
        .addr      (addr),
        .rmask     (rmask),
        .wmask     (wmask),
        .wdata     (wdata),
        .rdata     (rdata),
        .resp      (resp),
        .mem_addr  (mem_addr),
        .mem_read  (mem_read),
        .mem_write (mem_write),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .mem_resp  (mem_resp),
        .assoc_mode(assoc_mode)
    );

    line_memory line_memory_inst (
        .clk      (clk),
        .rst      (rst),
        .mem_addr (mem_addr),
        .mem_read (mem_read),
        .mem_write(mem_write),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .mem_resp (mem_resp)
    );

    always #20 clk = ~clk;

    // fill pattern of untouched memory words
    function automatic adaptive_cache_pkg::word_t fill_word(input adaptive_cache_pkg::addr_t wa);
        return (wa * 32'h9e37_79b1) ^ 32'h0bad_f00d;
    endfunction

    function automatic logic [7:0] model_byte(input adaptive_cache_pkg::addr_t ba);
        adaptive_cache_pkg::word_t w;
        if (model_mem.exists(ba)) begin
            return model_mem[ba];
        end
        w = fill_word({ba[31:2], 2'b00});
        return w[ba[1:0]*8 +: 8];
    endfunction

    function automatic adaptive_cache_pkg::word_t model_word(input adaptive_cache_pkg::addr_t wa);
        adaptive_cache_pkg::word_t w;
        for (int b = 0; b < 4; b++) begin
            w[b*8 +: 8] = model_byte({wa[31:2], 2'(b)});
        end
        return w;
    endfunction

    function automatic adaptive_cache_pkg::line_t model_line(input adaptive_cache_pkg::addr_t la);
        adaptive_cache_pkg::line_t l;
        for (int b = 0; b < adaptive_cache_pkg::LINE_BYTES; b++) begin
            l[b*8 +: 8] = model_byte({la[31:5], 5'(b)});
        end
        return l;
    endfunction

    task automatic model_write(input adaptive_cache_pkg::addr_t wa,
                               input adaptive_cache_pkg::byte_mask_t mask,
                               input adaptive_cache_pkg::word_t data);
        for (int b = 0; b < 4; b++) begin
            if (mask[b]) begin
                model_mem[{wa[31:2], 2'(b)}] = data[b*8 +: 8];
            end
        end
    endtask

    // conflict vs capacity classification per real miss
    task automatic tuner_update(input adaptive_cache_pkg::line_addr_t la);
        int   slot;
        logic found;
        found = 1'b0;
        slot  = -1;
        for (int i = 0; i < SH_ENTRIES; i++) begin
            if (sh_valid[i] && sh_line[i] == la) begin
                found = 1'b1;
            end
        end
        if (found) begin
            if (tune_cnt < TUNE_LIMIT) tune_cnt++;
        end else begin
            if (tune_cnt > -TUNE_LIMIT) tune_cnt--;
            for (int i = 0; i < SH_ENTRIES; i++) begin
                if (!sh_valid[i] && slot < 0) slot = i;
            end
            if (slot < 0) begin
                slot   = sh_ptr;
                sh_ptr = (sh_ptr + 1) % SH_ENTRIES;   // round robin once full
            end
            sh_valid[slot] = 1'b1;
            sh_line[slot]  = la;
        end
        if (tune_cnt == TUNE_LIMIT && exp_mode < 2) begin
            exp_mode++;
            tune_cnt = 0;
        end else if (tune_cnt == -TUNE_LIMIT && exp_mode > 0) begin
            exp_mode--;
            tune_cnt = 0;
        end
    endtask

    task automatic send_request(input adaptive_cache_pkg::addr_t a, input logic write,
                                input adaptive_cache_pkg::byte_mask_t mask,
                                input adaptive_cache_pkg::word_t data,
                                output adaptive_cache_pkg::word_t got, output int lat,
                                output logic saw_read);
        @(posedge clk);
        addr  <= a;
        wdata <= data;
        rmask <= write ? 4'h0 : mask;
        wmask <= write ? mask : 4'h0;
        @(posedge clk);
        rmask    <= 4'h0;
        wmask    <= 4'h0;
        lat      = 0;
        saw_read = 1'b0;
        do begin
            @(posedge clk);
            lat++;
            if (mem_read) saw_read = 1'b1;
        end while (!resp);
        got = rdata;   // sampled with resp
    endtask

    task automatic access(input adaptive_cache_pkg::addr_t a, input logic write,
                          input logic expect_hit);
        adaptive_cache_pkg::byte_mask_t mask;
        adaptive_cache_pkg::word_t      data;
        adaptive_cache_pkg::word_t      expected;
        adaptive_cache_pkg::word_t      got;
        adaptive_cache_pkg::line_addr_t la;
        int   lat;
        logic saw_read;
        logic fresh;
        la    = a[31:5];
        mask  = adaptive_cache_pkg::byte_mask_t'($urandom_range(15, 1));
        data  = $urandom;
        fresh = !touched.exists(la);
        touched[la] = 1'b1;
        if (write) model_write(a, mask, data);
        expected = model_word(a);
        send_request(a, write, mask, data, got, lat, saw_read);
        if (saw_read) tuner_update(la);
        if (!write) begin
            assert (got == expected) else begin
                data_errors++;
                $display("CHECK FAILED rdata addr %h got %h exp %h", a, got, expected);
            end
        end
        if (expect_hit) begin
            assert (lat == 1 && !saw_read) else begin
                timing_errors++;
                $display("access to %h was no one-cycle hit, took %0d cycles", a, lat);
            end
        end
        if (fresh) begin
            assert (saw_read) else begin
                timing_errors++;
                $display("first access to line of %h finished without a memory read", a);
            end
        end
        assert (assoc_mode == 2'(exp_mode)) else begin
            mode_errors++;
            $display("CHECK FAILED assoc_mode after %h got %h exp %h", a, assoc_mode,
                     2'(exp_mode));
        end
    endtask

    task automatic report_counts();
        $display("errors: data %0d, latency %0d, mode %0d, write-back %0d, other %0d",
                 data_errors, timing_errors, mode_errors, wb_errors, other_errors);
    endtask

    // write-back data against the model at the completing cycle
    always @(posedge clk) begin
        if (!rst && mem_write && mem_resp) begin
            wb_seen++;
            assert (mem_wdata == model_line(mem_addr)) else begin
                wb_errors++;
                $display("CHECK FAILED mem_wdata addr %h got %h exp %h", mem_addr, mem_wdata,
                         model_line(mem_addr));
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT) begin
            $display("timeout after %0d cycles, a request never completed", cycle_count);
            report_counts();
            $display("** FAIL **");
            $finish;
        end
    end

    initial begin : main
        adaptive_cache_pkg::tag_t     tag;
        adaptive_cache_pkg::set_idx_t set;
        adaptive_cache_pkg::addr_t    a;
        clk   = 1'b0;
        rst   = 1'b1;
        addr  = '0;
        rmask = '0;
        wmask = '0;
        wdata = '0;
        sh_ptr        = 0;
        tune_cnt      = 0;
        exp_mode      = 0;
        data_errors   = 0;
        timing_errors = 0;
        mode_errors   = 0;
        wb_errors     = 0;
        other_errors  = 0;
        wb_seen       = 0;
        cycle_count   = 0;
        for (int i = 0; i < SH_ENTRIES; i++) begin
            sh_valid[i] = 1'b0;
            sh_line[i]  = '0;
        end
        void'($urandom(25));
        repeat (10) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        assert (!resp && !mem_read && !mem_write && assoc_mode == 2'd0) else begin
            other_errors++;
            $display("CHECK FAILED after reset resp %h mem_read %h mem_write %h assoc_mode %h",
                     resp, mem_read, mem_write, assoc_mode);
        end

        // random traffic on 8 tags in sets 3 and 9
        for (int i = 0; i < N_RANDOM; i++) begin
            tag = 23'h1000 + 23'($urandom_range(7, 0));
            set = ($urandom_range(1, 0) == 1) ? 4'd9 : 4'd3;
            a   = {tag, set, 3'($urandom_range(7, 0)), 2'b00};
            access(a, ($urandom_range(1, 0) == 1), 1'b0);
            access(a, 1'b0, 1'b1);
        end

        // five lines cycling through set 0 with tag low bits 00
        for (int i = 0; i < N_BURST; i++) begin
            tag = 23'h2000 + 23'(4 * (i % 5));
            a   = {tag, 4'd0, 3'($urandom_range(7, 0)), 2'b00};
            access(a, ($urandom_range(1, 0) == 1), 1'b0);
        end
        assert (assoc_mode == 2'd2) else begin
            mode_errors++;
            $display("CHECK FAILED assoc_mode after conflict burst got %h exp 2", assoc_mode);
        end

        // enough fresh lines to overflow the shadow directory
        for (int i = 0; i < N_STREAM; i++) begin
            tag = 23'h3000 + 23'(i);
            set = 4'(4 + i % 8);
            a   = {tag, set, 3'($urandom_range(7, 0)), 2'b00};
            access(a, ($urandom_range(1, 0) == 1), 1'b0);
        end
        assert (assoc_mode == 2'd0) else begin
            mode_errors++;
            $display("CHECK FAILED assoc_mode after fresh stream got %h exp 0", assoc_mode);
        end

        // lines filled under other modes, the newest burst line still resident
        for (int i = 0; i < N_FINAL; i++) begin
            if (i < 5) begin
                a = {23'h2000 + 23'(4 * (4 - i)), 4'd0, 3'($urandom_range(7, 0)), 2'b00};
            end else begin
                tag = 23'h1000 + 23'($urandom_range(7, 0));
                a   = {tag, 4'd3, 3'($urandom_range(7, 0)), 2'b00};
            end
            access(a, 1'b0, (i == 0));
            access(a, 1'b0, 1'b1);
        end

        if (wb_seen == 0) begin
            other_errors++;
            $display("no dirty line was written back during the run");
        end
        report_counts();
        if (data_errors + timing_errors + mode_errors + wb_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tests/line_memory.sv */
`default_nettype none
`timescale 1ns/1ps

module line_memory (
    input  logic                       clk,
    input  logic                       rst,
    input  adaptive_cache_pkg::addr_t  mem_addr,
    input  logic                       mem_read,
    input  logic                       mem_write,
    input  adaptive_cache_pkg::line_t  mem_wdata,
    output adaptive_cache_pkg::line_t  mem_rdata,
    output logic                       mem_resp
);

    // sparse store, lines never written come from the fill pattern
    adaptive_cache_pkg::line_t lines [adaptive_cache_pkg::line_addr_t];
    logic busy;
    int   wait_cnt;

    function automatic adaptive_cache_pkg::line_t read_line(
        input adaptive_cache_pkg::line_addr_t la
    );
        adaptive_cache_pkg::line_t l;
        if (lines.exists(la)) begin
            return lines[la];
        end
        for (int w = 0; w < 8; w++) begin
            l[w*32 +: 32] = ({la, 3'(w), 2'b00} * 32'h9e37_79b1) ^ 32'h0bad_f00d;
        end
        return l;
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            mem_resp  <= 1'b0;
            mem_rdata <= '0;
            busy      <= 1'b0;
            wait_cnt  <= 0;
        end else begin
            mem_resp <= 1'b0;
            if (busy) begin
                if (wait_cnt == 0) begin
                    busy     <= 1'b0;
                    mem_resp <= 1'b1;
                    if (mem_write) begin
                        lines[mem_addr[31:5]] = mem_wdata;
                    end else begin
                        mem_rdata <= read_line(mem_addr[31:5]);
                    end
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if ((mem_read || mem_write) && !mem_resp) begin
                busy     <= 1'b1;
                wait_cnt <= $urandom_range(7, 0);   // resp 1 to 8 cycles later
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/adaptive_cache.sv */
`default_nettype none
`timescale 1ns/1ps

module adaptive_cache #(
    parameter int WAYS       = 4,
    parameter int TUNE_LIMIT = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  adaptive_cache_pkg::addr_t       addr,
    input  adaptive_cache_pkg::byte_mask_t  rmask,
    input  adaptive_cache_pkg::byte_mask_t  wmask,
    input  adaptive_cache_pkg::word_t       wdata,
    output adaptive_cache_pkg::word_t       rdata,
    output logic                            resp,
    output adaptive_cache_pkg::addr_t       mem_addr,
    output logic                            mem_read,
    output logic                            mem_write,
    output adaptive_cache_pkg::line_t       mem_wdata,
    input  adaptive_cache_pkg::line_t       mem_rdata,
    input  logic                            mem_resp,
    output adaptive_cache_pkg::assoc_mode_t assoc_mode
);

    localparam int WAY_BITS = $clog2(WAYS);

    adaptive_cache_pkg::addr_t      req_addr;
    adaptive_cache_pkg::word_t      req_wdata;
    adaptive_cache_pkg::byte_mask_t req_wmask;
    adaptive_cache_pkg::tag_t       req_tag;
    adaptive_cache_pkg::set_idx_t   req_set;
    adaptive_cache_pkg::line_addr_t req_line;
    logic [adaptive_cache_pkg::OFFSET_BITS-3:0] word_sel;
    logic strobe;

    adaptive_cache_pkg::line_t way_line [WAYS];
    adaptive_cache_pkg::tag_t  way_tag  [WAYS];
    logic [WAYS-1:0]           way_valid;
    logic [WAYS-1:0]           way_dirty;
    logic [WAYS-1:0]           way_we;

    logic                           hit;
    logic [WAY_BITS-1:0]            hit_way;
    logic [WAY_BITS-1:0]            victim_way;
    logic [WAY_BITS-1:0]            write_way;
    logic                           victim_dirty;
    logic                           line_we;
    logic                           refill;
    logic                           miss_event;
    logic                           touch;
    adaptive_cache_pkg::line_t      refill_line;
    adaptive_cache_pkg::line_t      line_data;
    adaptive_cache_pkg::line_mask_t line_mask;

    assign strobe = (|rmask) || (|wmask);

    // request hold registers, loaded on the strobe cycle
    always_ff @(posedge clk) begin
        if (strobe) begin
            req_addr  <= addr;
            req_wdata <= wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            req_wmask <= '0;
        end else if (strobe) begin
            req_wmask <= wmask;
        end
    end

    assign req_tag  = req_addr[adaptive_cache_pkg::ADDR_BITS-1 -: adaptive_cache_pkg::TAG_BITS];
    assign req_set  = req_addr[adaptive_cache_pkg::OFFSET_BITS +: adaptive_cache_pkg::SET_BITS];
    assign req_line = req_addr[adaptive_cache_pkg::ADDR_BITS-1:adaptive_cache_pkg::OFFSET_BITS];
    assign word_sel = req_addr[adaptive_cache_pkg::OFFSET_BITS-1:2];

    // full tag compare in every way, whatever the mode
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < WAYS; w++) begin
            if (way_valid[w] && way_tag[w] == req_tag) begin
                hit     = 1'b1;
                hit_way = WAY_BITS'(w);
            end
        end
    end

    assign rdata = way_line[hit_way][word_sel*32 +: 32];

    // memory line only valid with mem_resp, keep it for st_refill
    always_ff @(posedge clk) begin
        if (mem_read && mem_resp) begin
            refill_line <= mem_rdata;
        end
    end

    always_comb begin
        if (refill) begin
            line_mask = '1;
            line_data = refill_line;
        end else begin
            line_mask = '0;
            line_mask[word_sel*4 +: 4] = req_wmask;
            line_data = {(adaptive_cache_pkg::LINE_BITS/32){req_wdata}};   // word in every slot
        end
    end

    assign write_way    = refill ? victim_way : hit_way;
    assign victim_dirty = way_valid[victim_way] && way_dirty[victim_way];

    assign mem_wdata = way_line[victim_way];
    assign mem_addr  = mem_write
        ? {way_tag[victim_way], req_set, {adaptive_cache_pkg::OFFSET_BITS{1'b0}}}
        : {req_line, {adaptive_cache_pkg::OFFSET_BITS{1'b0}}};

    for (genvar w = 0; w < WAYS; w++) begin : g_way
        assign way_we[w] = line_we && (write_way == WAY_BITS'(w));

        way_store way_store_inst (
            .clk      (clk),
            .rst      (rst),
            .set      (req_set),
            .we       (way_we[w]),
            .line_mask(line_mask),
            .line_in  (line_data),
            .tag_in   (req_tag),
            .dirty_in (!refill),   // refill clean, write hit dirty
            .line_out (way_line[w]),
            .tag_out  (way_tag[w]),
            .valid    (way_valid[w]),
            .dirty    (way_dirty[w])
        );
    end

    plru_tree #(
        .WAYS(WAYS)
    ) plru_tree_inst (
        .clk       (clk),
        .rst       (rst),
        .set       (req_set),
        .touch     (touch),
        .touch_way (hit_way),
        .tag_low   (req_tag[1:0]),
        .assoc_mode(assoc_mode),
        .victim_way(victim_way)
    );

    cache_ctrl_fsm cache_ctrl_fsm_inst (
        .clk         (clk),
        .rst         (rst),
        .req         (strobe),
        .hit         (hit),
        .victim_dirty(victim_dirty),
        .is_write    (|req_wmask),
        .mem_resp    (mem_resp),
        .line_we     (line_we),
        .refill      (refill),
        .mem_read    (mem_read),
        .mem_write   (mem_write),
        .miss_event  (miss_event),
        .touch       (touch),
        .resp        (resp)
    );

    assoc_tuner #(
        .WAYS      (WAYS),
        .TUNE_LIMIT(TUNE_LIMIT)
    ) assoc_tuner_inst (
        .clk       (clk),
        .rst       (rst),
        .miss_event(miss_event),
        .miss_line (req_line),
        .assoc_mode(assoc_mode)
    );

endmodule

`default_nettype wire

/* verilog/assoc_tuner.sv */
`default_nettype none
`timescale 1ns/1ps

module assoc_tuner #(
    parameter int WAYS       = 4,
    parameter int TUNE_LIMIT = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            miss_event,
    input  adaptive_cache_pkg::line_addr_t  miss_line,
    output adaptive_cache_pkg::assoc_mode_t assoc_mode
);

    localparam int ENTRIES  = adaptive_cache_pkg::SETS * WAYS;
    localparam int IDX_BITS = $clog2(ENTRIES);
    localparam int CNT_BITS = $clog2(TUNE_LIMIT + 1) + 1;
    localparam logic signed [CNT_BITS-1:0] CNT_MAX = CNT_BITS'(TUNE_LIMIT);
    localparam logic signed [CNT_BITS-1:0] CNT_MIN = -CNT_MAX;

    // shadow directory, same capacity as the real cache
    logic [ENTRIES-1:0]             shadow_valid;
    adaptive_cache_pkg::line_addr_t shadow_line [ENTRIES];
    logic [IDX_BITS-1:0]            fill_ptr;
    logic [IDX_BITS-1:0]            free_idx;
    logic [IDX_BITS-1:0]            ins_idx;
    logic                           shadow_hit;
    logic                           free_found;
    logic signed [CNT_BITS-1:0]     count;
    logic signed [CNT_BITS-1:0]     count_step;

    always_comb begin : lookup
        shadow_hit = 1'b0;
        free_found = 1'b0;
        free_idx   = '0;
        for (int i = 0; i < ENTRIES; i++) begin
            if (shadow_valid[i] && shadow_line[i] == miss_line) begin
                shadow_hit = 1'b1;
            end
            if (!shadow_valid[i] && !free_found) begin
                free_found = 1'b1;
                free_idx   = IDX_BITS'(i);
            end
        end
    end

    // first free slot, else round-robin replacement
    assign ins_idx = free_found ? free_idx : fill_ptr;

    always_ff @(posedge clk) begin
        if (rst) begin
            shadow_valid <= '0;
            fill_ptr     <= '0;
        end else if (miss_event && !shadow_hit) begin
            shadow_valid[ins_idx] <= 1'b1;
            if (!free_found) begin
                fill_ptr <= fill_ptr + 1'b1;   // advances only on replacement
            end
        end
    end

    always_ff @(posedge clk) begin
        if (miss_event && !shadow_hit) begin
            shadow_line[ins_idx] <= miss_line;
        end
    end

    // conflict miss counts up, capacity/cold miss counts down
    always_comb begin
        if (shadow_hit) begin
            count_step = (count == CNT_MAX) ? CNT_MAX : CNT_BITS'(count + 1);
        end else begin
            count_step = (count == CNT_MIN) ? CNT_MIN : CNT_BITS'(count - 1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            count      <= '0;
            assoc_mode <= '0;
        end else if (miss_event) begin
            if (count_step == CNT_MAX && assoc_mode < 2'd2) begin
                assoc_mode <= assoc_mode + 2'd1;
                count      <= '0;
            end else if (count_step == CNT_MIN && assoc_mode > 2'd0) begin
                assoc_mode <= assoc_mode - 2'd1;
                count      <= '0;
            end else begin
                count <= count_step;   // saturated or still moving
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/cache_ctrl_fsm.sv */
`default_nettype none
`timescale 1ns/1ps

module cache_ctrl_fsm (
    input  logic clk,
    input  logic rst,
    input  logic req,
    input  logic hit,
    input  logic victim_dirty,
    input  logic is_write,
    input  logic mem_resp,
    output logic line_we,
    output logic refill,
    output logic mem_read,
    output logic mem_write,
    output logic miss_event,
    output logic touch,
    output logic resp
);

    adaptive_cache_pkg::ctrl_state_t state;
    adaptive_cache_pkg::ctrl_state_t state_next;
    logic wb_done;   // victim already written back for this miss
    logic need_wb;

    assign need_wb = victim_dirty && !wb_done;

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= adaptive_cache_pkg::st_idle;
            wb_done <= 1'b0;
        end else begin
            state <= state_next;
            if (mem_write && mem_resp) begin
                wb_done <= 1'b1;
            end else if (state == adaptive_cache_pkg::st_refill) begin
                wb_done <= 1'b0;
            end
        end
    end

    always_comb begin
        state_next = state;
        line_we    = 1'b0;
        refill     = 1'b0;
        mem_read   = 1'b0;
        mem_write  = 1'b0;
        miss_event = 1'b0;
        touch      = 1'b0;
        resp       = 1'b0;
        case (state)
            adaptive_cache_pkg::st_idle: begin
                if (req) begin
                    state_next = adaptive_cache_pkg::st_compare;
                end
            end
            adaptive_cache_pkg::st_compare: begin
                if (hit) begin
                    resp       = 1'b1;
                    touch      = 1'b1;
                    line_we    = is_write;   // write hit updates in place
                    state_next = adaptive_cache_pkg::st_idle;
                end else begin
                    miss_event = 1'b1;
                    state_next = need_wb ? adaptive_cache_pkg::st_writeback
                                         : adaptive_cache_pkg::st_allocate;
                end
            end
            // the victim can move when the mode steps on this miss,
            // so the dirty check is repeated once the mode has settled
            adaptive_cache_pkg::st_writeback: begin
                mem_write = victim_dirty;
                if (!victim_dirty || mem_resp) begin
                    state_next = adaptive_cache_pkg::st_allocate;
                end
            end
            adaptive_cache_pkg::st_allocate: begin
                if (need_wb) begin
                    state_next = adaptive_cache_pkg::st_writeback;
                end else begin
                    mem_read = 1'b1;
                    if (mem_resp) begin
                        state_next = adaptive_cache_pkg::st_refill;
                    end
                end
            end
            adaptive_cache_pkg::st_refill: begin
                line_we    = 1'b1;
                refill     = 1'b1;
                state_next = adaptive_cache_pkg::st_compare;   // retry, now hits
            end
            default: state_next = adaptive_cache_pkg::st_idle;
        endcase
    end

endmodule

`default_nettype wire

/* verilog/plru_tree.sv */
`default_nettype none
`timescale 1ns/1ps

module plru_tree #(
    parameter int WAYS = 4
) (
    input  logic                            clk,
    input  logic                            rst,
    input  adaptive_cache_pkg::set_idx_t    set,
    input  logic                            touch,
    input  logic [$clog2(WAYS)-1:0]         touch_way,
    input  logic [1:0]                      tag_low,
    input  adaptive_cache_pkg::assoc_mode_t assoc_mode,
    output logic [$clog2(WAYS)-1:0]         victim_way
);

    localparam int WAY_BITS = $clog2(WAYS);

    // heap order: node n has children 2n+1 (left) and 2n+2 (right)
    logic [WAYS-2:0] tree [adaptive_cache_pkg::SETS];
    logic [WAYS-2:0] tree_next;
    logic [WAY_BITS-1:0] walk_way;

    always_comb begin : touch_path
        int node;
        logic dir;
        tree_next = tree[set];
        node = 0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            dir = touch_way[WAY_BITS-1-lvl];
            tree_next[node] = ~dir;   // point away from touched way
            node = 2 * node + 1 + int'(dir);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < adaptive_cache_pkg::SETS; s++) begin
                tree[s] <= '0;
            end
        end else if (touch) begin
            tree[set] <= tree_next;
        end
    end

    // in two-way mode the root decision comes from the tag, not the tree
    always_comb begin : victim_walk
        int node;
        logic dir;
        node = 0;
        walk_way = '0;
        for (int lvl = 0; lvl < WAY_BITS; lvl++) begin
            if (lvl == 0 && assoc_mode == 2'd1) begin
                dir = tag_low[0];
            end else begin
                dir = tree[set][node];
            end
            walk_way[WAY_BITS-1-lvl] = dir;
            node = 2 * node + 1 + int'(dir);
        end
    end

    // tag_low is below WAYS, so the modulo is the value itself
    assign victim_way = (assoc_mode == 2'd0) ? WAY_BITS'(tag_low) : walk_way;

endmodule

`default_nettype wire

/* verilog/way_store.sv */
`default_nettype none
`timescale 1ns/1ps

module way_store (
    input  logic                           clk,
    input  logic                           rst,
    input  adaptive_cache_pkg::set_idx_t   set,
    input  logic                           we,
    input  adaptive_cache_pkg::line_mask_t line_mask,
    input  adaptive_cache_pkg::line_t      line_in,
    input  adaptive_cache_pkg::tag_t       tag_in,
    input  logic                           dirty_in,
    output adaptive_cache_pkg::line_t      line_out,
    output adaptive_cache_pkg::tag_t       tag_out,
    output logic                           valid,
    output logic                           dirty
);

    adaptive_cache_pkg::line_t line_mem [adaptive_cache_pkg::SETS];
    adaptive_cache_pkg::tag_t  tag_mem  [adaptive_cache_pkg::SETS];
    logic [adaptive_cache_pkg::SETS-1:0] valid_bits;
    logic [adaptive_cache_pkg::SETS-1:0] dirty_bits;

    // storage arrays, only the valid bits see reset
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < adaptive_cache_pkg::LINE_BYTES; b++) begin
                if (line_mask[b]) begin
                    line_mem[set][b*8 +: 8] <= line_in[b*8 +: 8];
                end
            end
            tag_mem[set]    <= tag_in;
            dirty_bits[set] <= dirty_in;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_bits <= '0;
        end else if (we) begin
            valid_bits[set] <= 1'b1;   // any write leaves the entry valid
        end
    end

    // async read on the held set index
    assign line_out = line_mem[set];
    assign tag_out  = tag_mem[set];
    assign valid    = valid_bits[set];
    assign dirty    = dirty_bits[set];

endmodule

`default_nettype wire

/* verilog/adaptive_cache_pkg.sv */
`default_nettype none

package adaptive_cache_pkg;

    // address split is tag | set | offset
    localparam int ADDR_BITS   = 32;
    localparam int OFFSET_BITS = 5;
    localparam int SET_BITS    = 4;
    localparam int SETS        = 16;
    localparam int TAG_BITS    = 23;
    localparam int LINE_BITS   = 256;
    localparam int LINE_BYTES  = 32;

    typedef logic [ADDR_BITS-1:0]           addr_t;
    typedef logic [31:0]                    word_t;
    typedef logic [LINE_BITS-1:0]           line_t;
    typedef logic [TAG_BITS-1:0]            tag_t;
    typedef logic [SET_BITS-1:0]            set_idx_t;
    typedef logic [TAG_BITS+SET_BITS-1:0]   line_addr_t;   // tag and set
    typedef logic [3:0]                     byte_mask_t;
    typedef logic [LINE_BYTES-1:0]          line_mask_t;   // one bit per line byte

    // 0 direct-mapped, 1 two-way, 2 four-way
    typedef logic [1:0] assoc_mode_t;

    typedef enum logic [2:0] {
        st_idle,
        st_compare,
        st_writeback,
        st_allocate,
        st_refill
    } ctrl_state_t;

endpackage

`default_nettype wire
